/* source/conv_pkg.sv */
`default_nettype none

package conv_pkg;

    // Image and memory sizes
    localparam int DATA_WIDTH  = 20;
    localparam int ADDR_WIDTH  = 12;
    localparam int IMAGE_WIDTH = 64;

    // Kernel geometry
    localparam int KERNEL_SIZE = 3;
    localparam int TAP_COUNT   = 9;

    // Accumulator and the slice kept from it
    localparam int ACC_WIDTH  = 40;
    localparam int FRAC_SHIFT = 16;

    typedef logic signed [DATA_WIDTH-1:0] pixel_t;
    typedef logic [ADDR_WIDTH-1:0]        addr_t;
    typedef logic signed [ACC_WIDTH-1:0]  acc_t;
    typedef logic [3:0]                   tap_index_t;
    typedef logic [2:0]                   csel_t;

    // Memory select for layer-0 writes
    localparam csel_t CSEL_LAYER0 = 3'b001;

    // Row-major, top-left tap first
    localparam pixel_t KERNEL_WEIGHTS [TAP_COUNT] = '{
        20'h0ab9e,
        20'h092d5,
        20'h06d43,
        20'h01004,
        20'hf8f71,
        20'hf6e54,
        20'hfa6d7,
        20'hfc834,
        20'hfac19
    };

endpackage

`default_nettype wire

/* source/conv_tap_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface conv_tap_if;

    logic                  valid;
    logic                  first;
    logic                  last;
    conv_pkg::tap_index_t  index;
    conv_pkg::pixel_t      pixel;
    // Output pixel this tap contributes to
    conv_pkg::addr_t       out_addr;

    modport scanner
    (
        output valid, first, last, index, pixel, out_addr
    );

    modport core
    (
        input valid, first, last, index, pixel, out_addr
    );

endinterface

`default_nettype wire

/* source/window_scanner.sv */
`timescale 1ns/100ps
`default_nettype none

module window_scanner
(
    input  logic              clk,
    input  logic              reset,
    input  logic              ready,
    input  conv_pkg::pixel_t  idata,
    output conv_pkg::addr_t   iaddr,
    output logic              frame_start,
    conv_tap_if.scanner       tap
);

    typedef enum logic
    {
        state_idle,
        state_scan
    } state_t;

    state_t               state;
    logic [5:0]           row;
    logic [5:0]           col;
    conv_pkg::tap_index_t tap_cnt;

    logic [1:0] krow;
    logic [1:0] kcol;
    logic [6:0] n_row;
    logic [6:0] n_col;
    logic [5:0] nb_row;
    logic [5:0] nb_col;
    logic       pad;
    logic       scanning;
    logic       last_tap;
    logic       last_pixel;

    assign scanning   = (state == state_scan);
    assign last_tap   = (tap_cnt == conv_pkg::tap_index_t'(conv_pkg::TAP_COUNT - 1));
    assign last_pixel = (row == 6'(conv_pkg::IMAGE_WIDTH - 1)) &&
                        (col == 6'(conv_pkg::IMAGE_WIDTH - 1));

    // Kernel offset of the current tap
    assign krow = 2'(tap_cnt / conv_pkg::KERNEL_SIZE);
    assign kcol = 2'(tap_cnt % conv_pkg::KERNEL_SIZE);

    // Neighbor position shifted up by one so the border sits at 0 and 65
    assign n_row  = {1'b0, row} + 7'(krow);
    assign n_col  = {1'b0, col} + 7'(kcol);
    assign nb_row = 6'(n_row - 7'd1);
    assign nb_col = 6'(n_col - 7'd1);
    assign pad    = (n_row == 7'd0) || (n_row == 7'(conv_pkg::IMAGE_WIDTH + 1)) ||
                    (n_col == 7'd0) || (n_col == 7'(conv_pkg::IMAGE_WIDTH + 1));

    assign iaddr       = (scanning && !pad) ? {nb_row, nb_col} : '0;
    assign frame_start = (state == state_idle) && ready;

    // Walk output pixels, nine taps each, no gaps
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state   <= state_idle;
            row     <= '0;
            col     <= '0;
            tap_cnt <= '0;
        end
        else if (frame_start)
        begin
            state   <= state_scan;
            row     <= '0;
            col     <= '0;
            tap_cnt <= '0;
        end
        else if (scanning)
        begin
            if (last_tap)
            begin
                tap_cnt <= '0;
                col     <= col + 6'd1;
                if (col == 6'(conv_pkg::IMAGE_WIDTH - 1))
                begin
                    row <= row + 6'd1;
                end
                if (last_pixel)
                begin
                    state <= state_idle;
                end
            end
            else
            begin
                tap_cnt <= tap_cnt + 4'd1;
            end
        end
    end

    // Tap control flags
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            tap.valid <= 1'b0;
            tap.first <= 1'b0;
            tap.last  <= 1'b0;
        end
        else
        begin
            tap.valid <= scanning;
            tap.first <= scanning && (tap_cnt == '0);
            tap.last  <= scanning && last_tap;
        end
    end

    // Tap payload, zero outside the image
    always_ff @(posedge clk)
    begin
        tap.index    <= tap_cnt;
        tap.pixel    <= pad ? '0 : idata;
        tap.out_addr <= {row, col};
    end

endmodule

`default_nettype wire

/* source/conv_mac.sv */
`timescale 1ns/100ps
`default_nettype none

module conv_mac
(
    input  logic              clk,
    input  logic              reset,
    conv_tap_if.core          tap,
    output logic              result_valid,
    output conv_pkg::pixel_t  result_data,
    output conv_pkg::addr_t   result_addr
);

    conv_pkg::pixel_t weight;
    conv_pkg::acc_t   product;
    conv_pkg::acc_t   acc;

    // Finished sum waiting for ReLU
    conv_pkg::acc_t   sum_reg;
    conv_pkg::addr_t  sum_addr;
    logic             sum_valid;
    conv_pkg::pixel_t trunc;

    assign weight  = conv_pkg::KERNEL_WEIGHTS[tap.index];
    assign product = conv_pkg::acc_t'(tap.pixel) * conv_pkg::acc_t'(weight);

    // Running sum, restarted by tap 0
    always_ff @(posedge clk)
    begin
        if (tap.valid)
        begin
            acc <= tap.first ? product : acc + product;
        end
    end

    // Last tap closes the sum while the next pixel starts accumulating
    always_ff @(posedge clk)
    begin
        if (tap.valid && tap.last)
        begin
            sum_reg  <= acc + product;
            sum_addr <= tap.out_addr;
        end
    end

    assign trunc = sum_reg[conv_pkg::FRAC_SHIFT +: conv_pkg::DATA_WIDTH];

    // ReLU on the kept slice
    always_ff @(posedge clk)
    begin
        if (sum_valid)
        begin
            result_data <= trunc[conv_pkg::DATA_WIDTH-1] ? '0 : trunc;
            result_addr <= sum_addr;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            sum_valid    <= 1'b0;
            result_valid <= 1'b0;
        end
        else
        begin
            sum_valid    <= tap.valid && tap.last;
            result_valid <= sum_valid;
        end
    end

endmodule

`default_nettype wire

/* source/layer0_writer.sv */
`timescale 1ns/100ps
`default_nettype none

module layer0_writer
(
    input  logic              clk,
    input  logic              reset,
    input  logic              frame_start,
    input  logic              result_valid,
    input  conv_pkg::pixel_t  result_data,
    input  conv_pkg::addr_t   result_addr,
    output logic              busy,
    output logic              cwr,
    output conv_pkg::csel_t   csel,
    output conv_pkg::addr_t   caddr_wr,
    output conv_pkg::pixel_t  cdata_wr
);

    logic final_write;

    assign final_write = cwr &&
        (caddr_wr == conv_pkg::addr_t'(conv_pkg::IMAGE_WIDTH * conv_pkg::IMAGE_WIDTH - 1));

    // One write cycle per result, all zero in between
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            cwr      <= 1'b0;
            csel     <= '0;
            caddr_wr <= '0;
            cdata_wr <= '0;
        end
        else
        begin
            cwr      <= result_valid;
            csel     <= result_valid ? conv_pkg::CSEL_LAYER0 : '0;
            caddr_wr <= result_valid ? result_addr : '0;
            cdata_wr <= result_valid ? result_data : '0;
        end
    end

    // Busy from frame start until the last address is written
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            busy <= 1'b0;
        end
        else if (frame_start)
        begin
            busy <= 1'b1;
        end
        else if (final_write)
        begin
            busy <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* source/conv_top.sv */
`timescale 1ns/100ps
`default_nettype none

module conv_top
(
    input  logic                clk,
    input  logic                reset,
    input  logic                ready,
    input  conv_pkg::pixel_t    idata,
    output logic                busy,
    output conv_pkg::addr_t     iaddr,
    output logic                cwr,
    output conv_pkg::csel_t     csel,
    output conv_pkg::addr_t     caddr_wr,
    output conv_pkg::pixel_t    cdata_wr
);

    logic             frame_start;
    logic             result_valid;
    conv_pkg::pixel_t result_data;
    conv_pkg::addr_t  result_addr;

    conv_tap_if tap_bus ();

    window_scanner u_scanner
    (
        .clk         (clk),
        .reset       (reset),
        .ready       (ready),
        .idata       (idata),
        .iaddr       (iaddr),
        .frame_start (frame_start),
        .tap         (tap_bus.scanner)
    );

    conv_mac u_mac
    (
        .clk          (clk),
        .reset        (reset),
        .tap          (tap_bus.core),
        .result_valid (result_valid),
        .result_data  (result_data),
        .result_addr  (result_addr)
    );

    layer0_writer u_writer
    (
        .clk          (clk),
        .reset        (reset),
        .frame_start  (frame_start),
        .result_valid (result_valid),
        .result_data  (result_data),
        .result_addr  (result_addr),
        .busy         (busy),
        .cwr          (cwr),
        .csel         (csel),
        .caddr_wr     (caddr_wr),
        .cdata_wr     (cdata_wr)
    );

endmodule

`default_nettype wire

/* tb/conv_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module conv_properties
(
    input logic             clk,
    input logic             reset,
    input logic             busy,
    input logic             cwr,
    input conv_pkg::csel_t  csel
);

    // Cycles since the last write, saturating at 9
    logic [3:0] since_cwr;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            since_cwr <= 4'd9;
        else if (cwr)
            since_cwr <= 4'd1;
        else if (since_cwr < 4'd9)
            since_cwr <= since_cwr + 4'd1;
    end

    csel_matches_cwr: assert property (@(posedge clk) disable iff (reset)
        cwr == (csel == conv_pkg::CSEL_LAYER0))
        else $error("csel does not follow cwr");

    write_only_while_busy: assert property (@(posedge clk) disable iff (reset)
        cwr |-> busy)
        else $error("cwr high while busy is low");

    write_spacing: assert property (@(posedge clk) disable iff (reset)
        cwr |-> (since_cwr >= 4'd9))
        else $error("two cwr pulses closer than 9 cycles");

endmodule

bind conv_top conv_properties props
(
    .clk   (clk),
    .reset (reset),
    .busy  (busy),
    .cwr   (cwr),
    .csel  (csel)
);

`default_nettype wire

/* tb/conv_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module conv_tb;

    localparam conv_pkg::addr_t LAST_ADDR = 12'hfff;
    localparam int PIXEL_COUNT  = 4096;
    localparam int FRAME_LIMIT  = PIXEL_COUNT * 9 + 32;
    // Six full frames at nine cycles per pixel
    localparam longint WATCHDOG_NS = 6 * 4096 * 9 * 10;

    logic                clk;
    logic                reset;
    logic                ready;
    conv_pkg::pixel_t    idata;
    logic                busy;
    conv_pkg::addr_t     iaddr;
    logic                cwr;
    conv_pkg::csel_t     csel;
    conv_pkg::addr_t     caddr_wr;
    conv_pkg::pixel_t    cdata_wr;

    // Host image memory and layer-0 memory models
    conv_pkg::pixel_t    image_mem [PIXEL_COUNT];
    conv_pkg::pixel_t    layer0_mem [PIXEL_COUNT];
    int                  write_count [PIXEL_COUNT];

    logic [31:0]         lfsr;
    int                  mismatch_count;
    int                  other_count;
    conv_pkg::addr_t     next_addr;
    logic                gap_check_on;
    int                  since_write;

    conv_top uut
    (
        .clk      (clk),
        .reset    (reset),
        .ready    (ready),
        .idata    (idata),
        .busy     (busy),
        .iaddr    (iaddr),
        .cwr      (cwr),
        .csel     (csel),
        .caddr_wr (caddr_wr),
        .cdata_wr (cdata_wr)
    );

    // Host memory answers in the same cycle
    assign idata = image_mem[iaddr];

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        $display("FAIL: see errors above");
        $finish;
    end

    task automatic check_pixel(input string name, input conv_pkg::pixel_t actual,
                               input conv_pkg::pixel_t expected);
        if (actual !== expected)
        begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s = %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_addr(input string name, input conv_pkg::addr_t actual,
                              input conv_pkg::addr_t expected);
        if (actual !== expected)
        begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s = %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_csel(input string name, input conv_pkg::csel_t actual,
                              input conv_pkg::csel_t expected);
        if (actual !== expected)
        begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s = %b, expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected)
        begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s = %b, expected %b", $time, name, actual, expected);
        end
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic conv_pkg::pixel_t random_pixel();
        conv_pkg::pixel_t p;
        for (int b = 0; b < conv_pkg::DATA_WIDTH; b++)
        begin
            p[b] = lfsr_bit();
        end
        return p;
    endfunction

    // Expected layer-0 value for output pixel (r, c)
    function automatic conv_pkg::pixel_t reference_pixel(input int r, input int c);
        longint           sum;
        int               nr;
        int               nc;
        conv_pkg::pixel_t px;
        conv_pkg::pixel_t w;
        conv_pkg::pixel_t kept;
        sum = 0;
        for (int kr = 0; kr < 3; kr++)
        begin
            for (int kc = 0; kc < 3; kc++)
            begin
                nr = r + kr - 1;
                nc = c + kc - 1;
                if (nr >= 0 && nr < 64 && nc >= 0 && nc < 64)
                    px = image_mem[conv_pkg::addr_t'(nr * 64 + nc)];
                else
                    px = '0;
                w   = conv_pkg::KERNEL_WEIGHTS[conv_pkg::tap_index_t'(kr * 3 + kc)];
                sum = sum + longint'(px) * longint'(w);
            end
        end
        kept = sum[35:16];
        // ReLU
        return kept[19] ? '0 : kept;
    endfunction

    task automatic fill_constant_image(input conv_pkg::pixel_t value);
        for (int i = 0; i < PIXEL_COUNT; i++)
        begin
            image_mem[conv_pkg::addr_t'(i)] = value;
        end
    endtask

    task automatic fill_random_image();
        for (int i = 0; i < PIXEL_COUNT; i++)
        begin
            image_mem[conv_pkg::addr_t'(i)] = random_pixel();
        end
    endtask

    // Read address of one tap, counted from the first scan cycle
    task automatic check_tap_address(input int step);
        int pix;
        int tap;
        int nr;
        int nc;
        pix = step / 9;
        tap = step % 9;
        nr  = pix / 64 + tap / 3 - 1;
        nc  = pix % 64 + tap % 3 - 1;
        // Padded taps read nothing
        if (nr >= 0 && nr < 64 && nc >= 0 && nc < 64)
        begin
            check_addr("iaddr", iaddr, conv_pkg::addr_t'(nr * 64 + nc));
        end
    endtask

    // Layer-0 capture, write order and write spacing
    always @(negedge clk)
    begin
        if (!reset)
        begin
            if (gap_check_on)
            begin
                since_write = since_write + 1;
                check_flag("cwr", cwr, since_write == 9);
            end
            if (cwr)
            begin
                layer0_mem[caddr_wr] = cdata_wr;
                write_count[caddr_wr]++;
                check_addr("caddr_wr", caddr_wr, next_addr);
                next_addr    = next_addr + 12'd1;
                since_write  = 0;
                gap_check_on = (caddr_wr != LAST_ADDR);
            end
        end
    end

    task automatic check_idle_outputs();
        check_flag("busy", busy, 1'b0);
        check_flag("cwr", cwr, 1'b0);
        check_csel("csel", csel, 3'b000);
        check_addr("caddr_wr", caddr_wr, 12'h000);
        check_pixel("cdata_wr", cdata_wr, 20'h00000);
    endtask

    task automatic verify_layer0();
        conv_pkg::addr_t a;
        for (int i = 0; i < PIXEL_COUNT; i++)
        begin
            a = conv_pkg::addr_t'(i);
            if (write_count[a] != 1)
            begin
                other_count++;
                $display("Address %0d was written %0d times in the frame", i, write_count[a]);
            end
            check_pixel($sformatf("cdata_wr[%0d]", i), layer0_mem[a],
                        reference_pixel(i / 64, i % 64));
        end
    endtask

    // Start one frame, wait for busy to drop, then compare layer 0
    task automatic run_frame();
        int   cycles;
        logic final_before;
        for (int i = 0; i < PIXEL_COUNT; i++)
        begin
            write_count[conv_pkg::addr_t'(i)] = 0;
            layer0_mem[conv_pkg::addr_t'(i)]  = '0;
        end
        next_addr    = '0;
        gap_check_on = 1'b0;
        final_before = 1'b0;
        cycles       = 0;
        @(posedge clk);
        #1 ready = 1'b1;
        @(posedge clk);
        #1 ready = 1'b0;
        @(negedge clk);
        check_flag("busy", busy, 1'b1);
        while (busy === 1'b1 && cycles < FRAME_LIMIT)
        begin
            if (cycles < PIXEL_COUNT * 9)
            begin
                check_tap_address(cycles);
            end
            final_before = cwr && (caddr_wr == LAST_ADDR);
            @(negedge clk);
            cycles++;
        end
        if (busy !== 1'b0)
        begin
            other_count++;
            $display("Frame did not finish within %0d cycles", FRAME_LIMIT);
        end
        else if (!final_before)
        begin
            other_count++;
            $display("busy fell without a write to the last address one cycle before");
        end
        verify_layer0();
    endtask

    task automatic test_reset_state();
        repeat (8) @(posedge clk);
        @(negedge clk);
        check_idle_outputs();
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;
        repeat (3) @(negedge clk);
        check_idle_outputs();
    endtask

    task automatic test_constant_image();
        fill_constant_image(20'h01000);
        run_frame();
    endtask

    task automatic test_random_image();
        fill_random_image();
        run_frame();
    endtask

    // Another frame after a short idle gap, with a fresh image
    task automatic test_restart();
        repeat (5) @(posedge clk);
        #1;
        fill_random_image();
        run_frame();
    endtask

    initial
    begin
        reset          = 1'b1;
        ready          = 1'b0;
        lfsr           = 32'h419;
        mismatch_count = 0;
        other_count    = 0;
        next_addr      = '0;
        gap_check_on   = 1'b0;
        since_write    = 0;
        fill_constant_image('0);
        test_reset_state();
        test_constant_image();
        test_random_image();
        test_restart();
        repeat (4) @(posedge clk);
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
source/conv_pkg.sv
source/conv_tap_if.sv
source/window_scanner.sv
source/conv_mac.sv
source/layer0_writer.sv
source/conv_top.sv
tb/conv_properties.sv
tb/conv_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the conv_tb simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module conv_tb -f tb.f --Mdir obj_dir -o conv_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/conv_sim)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "PASS: all tests"; then
    exit 0
fi
exit 1
